/* hdl/trap_config.svh */
/*
 * Build-time constants of the trap subsystem with the handler base address,
 * interrupt line count, reset value of mepc and exception cause codes
 */

`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

// All traps land at this base and interrupt n adds four times n
`define TRAP_MTVEC 32'h0000_0100

// Number of level-sensitive interrupt lines
`define TRAP_NUM_IRQ 16

// mepc value coming out of reset
`define TRAP_RESET_MEPC 32'h0000_0000

// Exception codes as written to the 31-bit code field of mcause
`define CAUSE_INSTR_FAULT 31'd1
`define CAUSE_ILLEGAL 31'd2
`define CAUSE_BREAKPOINT 31'd3
`define CAUSE_ECALL_M 31'd11
`define CAUSE_BUS_FAULT 31'd24

`endif

/* hdl/trap_pkg.sv */
/*
 * Shared types with the mcause union, the mstatus and dcsr structs
 * and the trap kind and CSR address enums
 */

package trap_pkg;

  // mcause is read as a raw word on the CSR port and decoded
  // as interrupt flag plus code by the controller and CSR file
  typedef struct packed {
    logic        irq;
    logic [30:0] code;
  } mcause_fields_t;

  typedef union packed {
    logic [31:0]    raw;
    mcause_fields_t fields;
  } mcause_t;

  // Only the two interrupt enable bits of mstatus are implemented
  typedef struct packed {
    logic mpie;
    logic mie;
  } mstatus_t;

  // Debug control with single-step as the only implemented field
  typedef struct packed {
    logic step;
  } dcsr_t;

  // Update the controller asks of the CSR file at a transfer
  typedef enum logic [2:0] {
    NONE = 3'd0,
    EXC  = 3'd1,
    IRQ  = 3'd2,
    MRET = 3'd3
  } trap_kind_e;

  // Standard machine and debug CSR addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MIE     = 12'h304,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342,
    CSR_MIP     = 12'h344,
    CSR_DCSR    = 12'h7B0
  } csr_addr_e;

endpackage

/* hdl/exc_prio.sv */
/*
 * Exception prioritizer for the instruction at the writeback boundary,
 * purely combinational
 */

`timescale 1ns/1ps

`include "trap_config.svh"

module exc_prio (
  input  logic        instr_valid_i,
  input  logic        illegal_i,
  input  logic        ecall_i,
  input  logic        ebrk_i,
  input  logic        bus_err_i,
  input  logic        mpu_err_i,
  output logic        exc_valid_o,
  output logic [30:0] exc_code_o
);

  //////////////////////////////////////////////////
  // Fixed priority select
  //////////////////////////////////////////////////

  // Fetch side faults come first since the instruction word itself
  // cannot be trusted, then decode faults, then the deliberate traps
  always_comb begin
    exc_valid_o = 1'b0;
    exc_code_o  = '0;
    if (instr_valid_i) begin
      if (mpu_err_i) begin
        exc_valid_o = 1'b1;
        exc_code_o  = `CAUSE_INSTR_FAULT;
      end else if (bus_err_i) begin
        exc_valid_o = 1'b1;
        exc_code_o  = `CAUSE_BUS_FAULT;
      end else if (illegal_i) begin
        exc_valid_o = 1'b1;
        exc_code_o  = `CAUSE_ILLEGAL;
      end else if (ecall_i) begin
        exc_valid_o = 1'b1;
        exc_code_o  = `CAUSE_ECALL_M;
      end else if (ebrk_i) begin
        exc_valid_o = 1'b1;
        exc_code_o  = `CAUSE_BREAKPOINT;
      end
    end
  end

endmodule

/* hdl/cs_registers.sv */
/*
 * Machine CSR file: mstatus, mie, mepc, mcause and dcsr with a software
 * write port, trap save and mret restore, mip mirrored from irq_i
 */

`timescale 1ns/1ps

`include "trap_config.svh"

module cs_registers (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  logic                     csr_we_i,
  input  trap_pkg::csr_addr_e      csr_addr_i,
  input  logic [31:0]              csr_wdata_i,
  input  trap_pkg::trap_kind_e     trap_kind_i,
  input  logic [31:0]              trap_pc_i,
  input  trap_pkg::mcause_t        trap_cause_i,
  input  logic [`TRAP_NUM_IRQ-1:0] irq_i,
  output logic [31:0]              csr_rdata_o,
  output trap_pkg::mstatus_t       mstatus_o,
  output logic [`TRAP_NUM_IRQ-1:0] mie_o,
  output logic [31:0]              mepc_o,
  output trap_pkg::dcsr_t          dcsr_o
);

  import trap_pkg::*;

  // Bit positions within the architectural 32-bit words
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int DCSR_STEP_BIT    = 2;

  mstatus_t                 mstatus_q;
  logic [`TRAP_NUM_IRQ-1:0] mie_q;
  logic [31:0]              mepc_q;
  mcause_t                  mcause_q;
  dcsr_t                    dcsr_q;

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Unimplemented bits and unknown addresses read as zero
  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        csr_rdata_o[MSTATUS_MIE_BIT]  = mstatus_q.mie;
        csr_rdata_o[MSTATUS_MPIE_BIT] = mstatus_q.mpie;
      end
      CSR_MIE:    csr_rdata_o[`TRAP_NUM_IRQ-1:0] = mie_q;
      CSR_MEPC:   csr_rdata_o = mepc_q;
      CSR_MCAUSE: csr_rdata_o = mcause_q.raw;
      CSR_MIP:    csr_rdata_o[`TRAP_NUM_IRQ-1:0] = irq_i;
      CSR_DCSR:   csr_rdata_o[DCSR_STEP_BIT] = dcsr_q.step;
      default:    csr_rdata_o = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Register update
  //////////////////////////////////////////////////

  // The trap update comes after the software write so that it takes
  // precedence when both hit the same register at one edge
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_q <= '0;
      mie_q     <= '0;
      mepc_q    <= `TRAP_RESET_MEPC;
      mcause_q  <= '0;
      dcsr_q    <= '0;
    end else begin
      if (csr_we_i) begin
        case (csr_addr_i)
          CSR_MSTATUS: begin
            mstatus_q.mie  <= csr_wdata_i[MSTATUS_MIE_BIT];
            mstatus_q.mpie <= csr_wdata_i[MSTATUS_MPIE_BIT];
          end
          CSR_MIE:  mie_q <= csr_wdata_i[`TRAP_NUM_IRQ-1:0];
          CSR_MEPC: mepc_q <= csr_wdata_i;
          CSR_MCAUSE: begin
            // All legal codes fit in five bits, upper code bits stay zero
            mcause_q.fields.irq  <= csr_wdata_i[31];
            mcause_q.fields.code <= {26'd0, csr_wdata_i[4:0]};
          end
          CSR_DCSR: dcsr_q.step <= csr_wdata_i[DCSR_STEP_BIT];
          default: ;
        endcase
      end
      case (trap_kind_i)
        EXC, IRQ: begin
          mepc_q         <= trap_pc_i;
          mcause_q       <= trap_cause_i;
          mstatus_q.mpie <= mstatus_q.mie;
          mstatus_q.mie  <= 1'b0;
        end
        MRET: begin
          mstatus_q.mie  <= mstatus_q.mpie;
          mstatus_q.mpie <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign mstatus_o = mstatus_q;
  assign mie_o     = mie_q;
  assign mepc_o    = mepc_q;
  assign dcsr_o    = dcsr_q;

  // mepc only moves on a trap save or a software write to mepc
  a_mepc_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    (!(trap_kind_i inside {EXC, IRQ}) && !(csr_we_i && csr_addr_i == CSR_MEPC))
    |=> $stable(mepc_q))
    else $error("mepc changed without a trap or software write");

endmodule

/* hdl/trap_ctrl.sv */
/*
 * Boundary controller: picks retire, interrupt, exception or mret for
 * each transfer, registers the outcome and tracks single-step debug state
 */

`timescale 1ns/1ps

`include "trap_config.svh"

module trap_ctrl (
  input  logic                             clk,
  input  logic                             rst_ni,
  input  logic                             instr_valid_i,
  input  logic [31:0]                      instr_pc_i,
  input  logic                             mret_i,
  input  logic                             exc_valid_i,
  input  logic [30:0]                      exc_code_i,
  input  logic [`TRAP_NUM_IRQ-1:0]         irq_i,
  input  logic [`TRAP_NUM_IRQ-1:0]         mie_i,
  input  trap_pkg::mstatus_t               mstatus_i,
  input  logic [31:0]                      mepc_i,
  input  trap_pkg::dcsr_t                  dcsr_i,
  input  logic                             debug_resume_i,
  output logic                             instr_ready_o,
  output trap_pkg::trap_kind_e             trap_kind_o,
  output logic [31:0]                      trap_pc_o,
  output trap_pkg::mcause_t                trap_cause_o,
  output logic                             retire_o,
  output logic [31:0]                      retire_pc_o,
  output logic                             pc_set_o,
  output logic [31:0]                      pc_target_o,
  output logic                             irq_ack_o,
  output logic [$clog2(`TRAP_NUM_IRQ)-1:0] irq_id_o,
  output logic                             debug_mode_o
);

  import trap_pkg::*;

  localparam int IRQ_ID_W = $clog2(`TRAP_NUM_IRQ);

  logic                     accept;
  logic [`TRAP_NUM_IRQ-1:0] irq_pending;
  logic                     irq_take;
  logic [IRQ_ID_W-1:0]      irq_id;
  logic [31:0]              target;
  logic                     debug_q;

  // No new instruction is taken while halted in debug mode
  assign instr_ready_o = !debug_q;
  assign accept        = instr_valid_i && instr_ready_o;

  //////////////////////////////////////////////////
  // Interrupt select
  //////////////////////////////////////////////////

  assign irq_pending = irq_i & mie_i;
  assign irq_take    = mstatus_i.mie && (|irq_pending);

  // Walk downwards so the lowest pending line is the one that sticks
  always_comb begin
    irq_id = '0;
    for (int i = `TRAP_NUM_IRQ - 1; i >= 0; i--) begin
      if (irq_pending[i]) begin
        irq_id = IRQ_ID_W'(i);
      end
    end
  end

  //////////////////////////////////////////////////
  // Outcome decision
  //////////////////////////////////////////////////

  // Interrupt beats exception, exception beats mret, anything else retires
  always_comb begin
    trap_kind_o  = NONE;
    trap_cause_o = '0;
    target       = `TRAP_MTVEC;
    if (accept) begin
      if (irq_take) begin
        trap_kind_o               = IRQ;
        trap_cause_o.fields.irq  = 1'b1;
        trap_cause_o.fields.code = 31'(irq_id);
        target                    = `TRAP_MTVEC + (32'(irq_id) << 2);
      end else if (exc_valid_i) begin
        trap_kind_o               = EXC;
        trap_cause_o.fields.code = exc_code_i;
      end else if (mret_i) begin
        trap_kind_o = MRET;
        target      = mepc_i;
      end
    end
  end

  assign trap_pc_o = instr_pc_i;

  // Control flags of the registered outcome plus the debug halt state
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_o  <= 1'b0;
      pc_set_o  <= 1'b0;
      irq_ack_o <= 1'b0;
      debug_q   <= 1'b0;
    end else begin
      retire_o  <= accept && (trap_kind_o == NONE);
      pc_set_o  <= trap_kind_o != NONE;
      irq_ack_o <= trap_kind_o == IRQ;
      if (accept && dcsr_i.step) begin
        debug_q <= 1'b1;
      end else if (debug_resume_i) begin
        debug_q <= 1'b0;
      end
    end
  end

  // Addresses that go with the flags above
  always_ff @(posedge clk) begin
    if (accept) begin
      retire_pc_o <= instr_pc_i;
      pc_target_o <= target;
      irq_id_o    <= irq_id;
    end
  end

  assign debug_mode_o = debug_q;

  // The acknowledged line was enabled in mie and globally at transfer time
  a_irq_enabled: assert property (@(posedge clk) disable iff (!rst_ni)
    irq_ack_o |-> $past(mstatus_i.mie) &&
                  (|($past(mie_i) & (`TRAP_NUM_IRQ'(1) << irq_id_o))))
    else $error("interrupt taken while not enabled");

  // The CSR file must have dropped global enable once a trap is taken
  a_mie_cleared: assert property (@(posedge clk) disable iff (!rst_ni)
    (trap_kind_o inside {EXC, IRQ}) |=> !mstatus_i.mie)
    else $error("mstatus.mie still set after trap");

  // A stepped transfer gives one outcome in debug mode and nothing after it
  a_single_step: assert property (@(posedge clk) disable iff (!rst_ni)
    (accept && dcsr_i.step && !debug_mode_o) |=>
    (debug_mode_o && (retire_o ^ pc_set_o)) ##1 !(retire_o || pc_set_o))
    else $error("more than one instruction completed while stepping");

endmodule

/* hdl/trap_unit.sv */
/*
 * Top of the trap and debug-step subsystem, joins the exception
 * prioritizer, the boundary controller and the CSR file
 */

`timescale 1ns/1ps

`include "trap_config.svh"

module trap_unit (
  input  logic                             clk,
  input  logic                             rst_ni,
  input  logic                             instr_valid_i,
  input  logic [31:0]                      instr_pc_i,
  input  logic                             illegal_i,
  input  logic                             ecall_i,
  input  logic                             ebrk_i,
  input  logic                             mret_i,
  input  logic                             bus_err_i,
  input  logic                             mpu_err_i,
  output logic                             instr_ready_o,
  input  logic [`TRAP_NUM_IRQ-1:0]         irq_i,
  input  logic                             csr_we_i,
  input  trap_pkg::csr_addr_e              csr_addr_i,
  input  logic [31:0]                      csr_wdata_i,
  output logic [31:0]                      csr_rdata_o,
  output logic                             retire_o,
  output logic [31:0]                      retire_pc_o,
  output logic                             pc_set_o,
  output logic [31:0]                      pc_target_o,
  output logic                             irq_ack_o,
  output logic [$clog2(`TRAP_NUM_IRQ)-1:0] irq_id_o,
  output logic                             debug_mode_o,
  input  logic                             debug_resume_i
);

  import trap_pkg::*;

  // Prioritizer to controller
  logic        exc_valid;
  logic [30:0] exc_code;

  // Controller to CSR file
  trap_kind_e  trap_kind;
  logic [31:0] trap_pc;
  mcause_t     trap_cause;

  // CSR state fed back to the controller
  mstatus_t                 mstatus;
  logic [`TRAP_NUM_IRQ-1:0] mie;
  logic [31:0]              mepc;
  dcsr_t                    dcsr;

  exc_prio exc_prio_inst (
    .instr_valid_i (instr_valid_i),
    .illegal_i     (illegal_i),
    .ecall_i       (ecall_i),
    .ebrk_i        (ebrk_i),
    .bus_err_i     (bus_err_i),
    .mpu_err_i     (mpu_err_i),
    .exc_valid_o   (exc_valid),
    .exc_code_o    (exc_code)
  );

  trap_ctrl trap_ctrl_inst (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_pc_i     (instr_pc_i),
    .mret_i         (mret_i),
    .exc_valid_i    (exc_valid),
    .exc_code_i     (exc_code),
    .irq_i          (irq_i),
    .mie_i          (mie),
    .mstatus_i      (mstatus),
    .mepc_i         (mepc),
    .dcsr_i         (dcsr),
    .debug_resume_i (debug_resume_i),
    .instr_ready_o  (instr_ready_o),
    .trap_kind_o    (trap_kind),
    .trap_pc_o      (trap_pc),
    .trap_cause_o   (trap_cause),
    .retire_o       (retire_o),
    .retire_pc_o    (retire_pc_o),
    .pc_set_o       (pc_set_o),
    .pc_target_o    (pc_target_o),
    .irq_ack_o      (irq_ack_o),
    .irq_id_o       (irq_id_o),
    .debug_mode_o   (debug_mode_o)
  );

  cs_registers cs_registers_inst (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .csr_we_i     (csr_we_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .trap_kind_i  (trap_kind),
    .trap_pc_i    (trap_pc),
    .trap_cause_i (trap_cause),
    .irq_i        (irq_i),
    .csr_rdata_o  (csr_rdata_o),
    .mstatus_o    (mstatus),
    .mie_o        (mie),
    .mepc_o       (mepc),
    .dcsr_o       (dcsr)
  );

endmodule

/* bench/trap_unit_tb.sv */
/*
 * Testbench for trap_unit with clock, reset, instruction and CSR stimulus,
 * reference model with compare process, watchdog and report
 */

`timescale 1ns/1ps

`include "trap_config.svh"

module trap_unit_tb;

  import trap_pkg::*;

  localparam int ID_W     = $clog2(`TRAP_NUM_IRQ);
  localparam int HS_LIMIT = 20;
  // Cycle budget of reset, retire burst, 12 traps, interrupt, mret and single step
  localparam int RUN_CYCLES = 5 + 25 + 12 * 10 + 40 + 20 + 40;

  // Expected outcome of one transfer
  typedef struct packed {
    trap_kind_e  kind;
    logic [31:0] pc;
    logic [31:0] target;
    mcause_t     cause;
    logic [ID_W-1:0] irq_id;
    logic        debug;
  } outcome_t;

  logic clk;
  logic rst_ni;
  logic instr_valid_i;
  logic [31:0] instr_pc_i;
  logic illegal_i;
  logic ecall_i;
  logic ebrk_i;
  logic mret_i;
  logic bus_err_i;
  logic mpu_err_i;
  logic instr_ready_o;
  logic [`TRAP_NUM_IRQ-1:0] irq_i;
  logic csr_we_i;
  csr_addr_e csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic retire_o;
  logic [31:0] retire_pc_o;
  logic pc_set_o;
  logic [31:0] pc_target_o;
  logic irq_ack_o;
  logic [ID_W-1:0] irq_id_o;
  logic debug_mode_o;
  logic debug_resume_i;

  // Model of the architectural CSR state
  logic model_mie_bit;
  logic model_mpie;
  logic [`TRAP_NUM_IRQ-1:0] model_mie;
  logic [31:0] model_mepc;
  mcause_t model_mcause;
  logic model_step;

  outcome_t exp_q[$];
  int checks = 0;
  int errors = 0;
  int seed = 76;
  string cur_test = "reset";

  trap_unit trap_unit_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", cur_test, name, exp, act);
    end
  endtask

  task automatic check_cause(input string name, input mcause_t exp, input mcause_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", cur_test, name, exp.raw, act.raw);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s: expected %b, actual %b", cur_test, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Flags are {mpu, bus, illegal, ecall, ebreak, mret}
  function automatic outcome_t predict_outcome(input logic [31:0] pc, input logic [5:0] flags,
                                               input logic [`TRAP_NUM_IRQ-1:0] irq);
    outcome_t o;
    logic [`TRAP_NUM_IRQ-1:0] pend;
    int line;
    o = '0;
    o.kind = NONE;
    o.pc = pc;
    o.target = `TRAP_MTVEC;
    o.debug = model_step;
    pend = irq & model_mie;
    line = 0;
    // A pending enabled interrupt wins over everything the instruction carries
    if (model_mie_bit && pend != '0) begin
      while (!pend[line]) begin
        line++;
      end
      o.kind = IRQ;
      o.target = `TRAP_MTVEC + 32'(4 * line);
      o.cause.raw = {1'b1, 31'(line)};
      o.irq_id = ID_W'(line);
    end else if (flags[5:1] != '0) begin
      o.kind = EXC;
      if (flags[5]) begin
        o.cause.raw = {1'b0, `CAUSE_INSTR_FAULT};
      end else if (flags[4]) begin
        o.cause.raw = {1'b0, `CAUSE_BUS_FAULT};
      end else if (flags[3]) begin
        o.cause.raw = {1'b0, `CAUSE_ILLEGAL};
      end else if (flags[2]) begin
        o.cause.raw = {1'b0, `CAUSE_ECALL_M};
      end else begin
        o.cause.raw = {1'b0, `CAUSE_BREAKPOINT};
      end
    end else if (flags[0]) begin
      o.kind = MRET;
      o.target = model_mepc;
    end
    return o;
  endfunction

  // Traps stack mie into mpie and mret pops it back
  function automatic void apply_outcome(input outcome_t o);
    if (o.kind == EXC || o.kind == IRQ) begin
      model_mepc = o.pc;
      model_mcause = o.cause;
      model_mpie = model_mie_bit;
      model_mie_bit = 1'b0;
    end else if (o.kind == MRET) begin
      model_mie_bit = model_mpie;
      model_mpie = 1'b1;
    end
  endfunction

  // Architectural layout with mie at bit 3 and mpie at bit 7
  function automatic logic [31:0] mstatus_word();
    return {24'd0, model_mpie, 3'd0, model_mie_bit, 3'd0};
  endfunction

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // Returns at the negedge before the transfer edge, so calls chain back to back
  task automatic send_instr(input logic [31:0] pc, input logic [5:0] flags);
    outcome_t o;
    int waited;
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_pc_i <= pc;
    {mpu_err_i, bus_err_i, illegal_i, ecall_i, ebrk_i, mret_i} <= flags;
    o = predict_outcome(pc, flags, irq_i);
    exp_q.push_back(o);
    apply_outcome(o);
    waited = 0;
    @(negedge clk);
    while (!instr_ready_o && waited < HS_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!instr_ready_o) begin
      errors++;
      $display("ERROR %s: instr_ready_o stayed low for %0d cycles at pc %h",
               cur_test, waited, pc);
    end
  endtask

  task automatic end_burst();
    @(posedge clk);
    instr_valid_i <= 1'b0;
    {mpu_err_i, bus_err_i, illegal_i, ecall_i, ebrk_i, mret_i} <= '0;
    repeat (2) @(negedge clk);
  endtask

  task automatic write_csr(input csr_addr_e addr, input logic [31:0] data);
    @(posedge clk);
    csr_we_i <= 1'b1;
    csr_addr_i <= addr;
    csr_wdata_i <= data;
    @(posedge clk);
    csr_we_i <= 1'b0;
    case (addr)
      CSR_MSTATUS: begin
        model_mie_bit = data[3];
        model_mpie = data[7];
      end
      CSR_MIE: model_mie = data[`TRAP_NUM_IRQ-1:0];
      CSR_DCSR: model_step = data[2];
      default: ;
    endcase
  endtask

  task automatic read_csr(input csr_addr_e addr, output logic [31:0] data);
    @(posedge clk);
    csr_addr_i <= addr;
    @(negedge clk);
    data = csr_rdata_o;
  endtask

  task automatic finish_test(input int num, input int start_errors);
    $display("test %0d %s: %0d errors", num, cur_test, errors - start_errors);
  endtask

  //////////////////////////////////////////////////
  // Compare process and watchdog
  //////////////////////////////////////////////////

  // Outputs are sampled at the negedge after each transfer edge
  initial begin : compare_outcomes
    outcome_t e;
    forever begin
      @(posedge clk);
      if (rst_ni && instr_valid_i && instr_ready_o) begin
        @(negedge clk);
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR %s: transfer seen with no expected outcome", cur_test);
        end else begin
          e = exp_q.pop_front();
          if (!retire_o && !pc_set_o) begin
            errors++;
            $display("ERROR %s: no retire or pc_set after transfer of pc %h", cur_test, e.pc);
          end
          check_bit("retire_o", e.kind == NONE, retire_o);
          check_bit("pc_set_o", e.kind != NONE, pc_set_o);
          check_bit("irq_ack_o", e.kind == IRQ, irq_ack_o);
          check_bit("debug_mode_o", e.debug, debug_mode_o);
          if (e.kind == NONE) begin
            check_word("retire_pc_o", e.pc, retire_pc_o);
          end else begin
            check_word("pc_target_o", e.target, pc_target_o);
          end
          if (e.kind == IRQ) begin
            check_word("irq_id_o", 32'(e.irq_id), 32'(irq_id_o));
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(RUN_CYCLES * 20 + 2000);
    $display("ERROR: watchdog expired, the run did not reach its end");
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : run_tests
    logic [31:0] rd;
    logic [31:0] pc;
    logic [5:0] flags;
    mcause_t cause_rd;
    int start_err;
    rst_ni = 1'b0;
    instr_valid_i = 1'b0;
    instr_pc_i = '0;
    {mpu_err_i, bus_err_i, illegal_i, ecall_i, ebrk_i, mret_i} = '0;
    irq_i = '0;
    csr_we_i = 1'b0;
    csr_addr_i = CSR_MSTATUS;
    csr_wdata_i = '0;
    debug_resume_i = 1'b0;
    model_mie_bit = 1'b0;
    model_mpie = 1'b0;
    model_mie = '0;
    model_mepc = `TRAP_RESET_MEPC;
    model_mcause = '0;
    model_step = 1'b0;
    repeat (5) @(posedge clk);
    rst_ni <= 1'b1;

    // Reset state, then a burst of plain instructions
    cur_test = "retire burst";
    start_err = errors;
    @(negedge clk);
    check_bit("instr_ready_o after reset", 1'b1, instr_ready_o);
    check_bit("debug_mode_o after reset", 1'b0, debug_mode_o);
    read_csr(CSR_MEPC, rd);
    check_word("mepc after reset", `TRAP_RESET_MEPC, rd);
    for (int i = 0; i < 8; i++) begin
      send_instr($random(seed) & 32'hFFFF_FFFC, 6'b0);
    end
    end_burst();
    finish_test(1, start_err);

    // At least one exception flag is always set and mret rides along at random
    cur_test = "random exceptions";
    start_err = errors;
    for (int i = 0; i < 12; i++) begin
      pc = $random(seed) & 32'hFFFF_FFFC;
      flags = 6'($random(seed));
      if (flags[5:1] == '0) begin
        flags[3] = 1'b1;
      end
      send_instr(pc, flags);
      end_burst();
      read_csr(CSR_MEPC, rd);
      check_word("mepc", pc, rd);
      read_csr(CSR_MCAUSE, rd);
      cause_rd = rd;
      check_cause("mcause", model_mcause, cause_rd);
    end
    finish_test(2, start_err);

    // Lines 1, 3 and 5 pending while only 3 and 5 get enabled
    cur_test = "interrupt";
    start_err = errors;
    @(posedge clk);
    irq_i <= `TRAP_NUM_IRQ'(32'h2A);
    send_instr(32'h0000_1000, 6'b0);
    end_burst();
    write_csr(CSR_MIE, 32'h28);
    send_instr(32'h0000_1004, 6'b0);
    end_burst();
    write_csr(CSR_MSTATUS, 32'h8);
    send_instr(32'h0000_1008, 6'b0);
    end_burst();
    read_csr(CSR_MCAUSE, rd);
    cause_rd = rd;
    check_cause("mcause", model_mcause, cause_rd);
    read_csr(CSR_MSTATUS, rd);
    check_word("mstatus", mstatus_word(), rd);
    read_csr(CSR_MEPC, rd);
    check_word("mepc", 32'h0000_1008, rd);
    @(posedge clk);
    irq_i <= '0;
    finish_test(3, start_err);

    // ecall then mret back to it
    cur_test = "mret";
    start_err = errors;
    write_csr(CSR_MSTATUS, 32'h8);
    send_instr(32'h0000_3000, 6'b000100);
    send_instr(32'h0000_0100, 6'b000001);
    end_burst();
    read_csr(CSR_MSTATUS, rd);
    check_word("mstatus", mstatus_word(), rd);
    finish_test(4, start_err);

    // Step one instruction, hold the next one while halted, then resume
    cur_test = "single step";
    start_err = errors;
    write_csr(CSR_DCSR, 32'h4);
    send_instr(32'h0000_2000, 6'b0);
    fork
      send_instr(32'h0000_2004, 6'b0);
      begin
        repeat (5) begin
          @(negedge clk);
          check_bit("instr_ready_o while halted", 1'b0, instr_ready_o);
        end
        check_bit("debug_mode_o while halted", 1'b1, debug_mode_o);
        @(posedge clk);
        debug_resume_i <= 1'b1;
        @(posedge clk);
        debug_resume_i <= 1'b0;
      end
    join
    end_burst();
    check_bit("debug_mode_o after second step", 1'b1, debug_mode_o);
    write_csr(CSR_DCSR, 32'h0);
    @(posedge clk);
    debug_resume_i <= 1'b1;
    @(posedge clk);
    debug_resume_i <= 1'b0;
    @(negedge clk);
    check_bit("debug_mode_o after resume", 1'b0, debug_mode_o);
    check_bit("instr_ready_o after resume", 1'b1, instr_ready_o);
    finish_test(5, start_err);

    $display("checks: %0d, errors: %0d, outcomes never seen: %0d",
             checks, errors, exp_q.size());
    if (errors == 0 && exp_q.size() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+hdl
hdl/trap_pkg.sv
hdl/exc_prio.sv
hdl/cs_registers.sv
hdl/trap_ctrl.sv
hdl/trap_unit.sv
bench/trap_unit_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := trap_unit_tb
RTL_TOP    := trap_unit
FILELIST   := list.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides the result, the simulator exit code alone does not
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
